// File: source/aes_pkg.sv
package aes_pkg;

    localparam int unsigned          ROUND_W    = 4;
    localparam logic [ROUND_W-1:0]   NUM_ROUNDS = 4'd10;   // full rounds after first add

    // one phase per cycle, code 3'b110 unused
    typedef enum logic [2:0] {
        PH_IDLE = 3'b000,
        PH_ADD  = 3'b001,
        PH_SUB  = 3'b010,
        PH_EXP  = 3'b011,
        PH_SHI  = 3'b100,
        PH_MIX  = 3'b101,
        PH_DONE = 3'b111
    } aes_phase_e;

    // byte i sits in row i%4, column i/4
    typedef union packed {
        logic [0:15][7:0] bytes;   // byte 0 is msb
        logic [0:3][31:0] cols;    // column 0 is msb
    } aes_block_u;

    typedef struct packed {
        aes_block_u text;
        aes_block_u key;
    } aes_req_t;

    localparam logic [0:255][7:0] SBOX_TABLE = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    function automatic logic [7:0] aes_sbox(input logic [7:0] b);
        return SBOX_TABLE[b];
    endfunction

    function automatic logic [7:0] aes_rcon(input logic [ROUND_W-1:0] r);
        logic [7:0] rc;
        case (r)
            4'd1:    rc = 8'h01;
            4'd2:    rc = 8'h02;
            4'd3:    rc = 8'h04;
            4'd4:    rc = 8'h08;
            4'd5:    rc = 8'h10;
            4'd6:    rc = 8'h20;
            4'd7:    rc = 8'h40;
            4'd8:    rc = 8'h80;
            4'd9:    rc = 8'h1b;   // reduced by the field polynomial
            4'd10:   rc = 8'h36;
            default: rc = 8'h00;
        endcase
        return rc;
    endfunction

    // multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] aes_xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

endpackage

// File: source/aes_ctrl.sv
`timescale 1ns/100ps

module aes_ctrl (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      in_valid,
    output logic                      in_ready,
    output logic                      out_valid,
    input  logic                      out_ready,
    output logic                      load,
    output aes_pkg::aes_phase_e       phase,
    output logic [aes_pkg::ROUND_W-1:0] round
);
    import aes_pkg::*;

    aes_phase_e         phase_nxt;
    logic [ROUND_W-1:0] round_nxt;

    assign in_ready  = (phase == PH_IDLE);
    assign out_valid = (phase == PH_DONE);
    assign load      = in_valid & in_ready;   // one cycle per accepted block

    always_comb begin
        phase_nxt = phase;
        round_nxt = round;
        case (phase)
            PH_IDLE: begin
                if (load) begin
                    phase_nxt = PH_ADD;
                    round_nxt = '0;   // initial key add
                end
            end
            PH_ADD: begin
                if (round == NUM_ROUNDS) begin
                    phase_nxt = PH_DONE;
                end else begin
                    phase_nxt = PH_SUB;
                    round_nxt = round + 1'b1;
                end
            end
            PH_SUB:  phase_nxt = PH_EXP;
            PH_EXP:  phase_nxt = PH_SHI;
            PH_SHI:  phase_nxt = (round == NUM_ROUNDS) ? PH_ADD : PH_MIX;   // last round skips mix
            PH_MIX:  phase_nxt = PH_ADD;
            PH_DONE: if (out_ready) phase_nxt = PH_IDLE;
            default: phase_nxt = PH_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            phase <= PH_IDLE;
            round <= '0;
        end else begin
            phase <= phase_nxt;
            round <= round_nxt;
        end
    end

endmodule

// File: source/aes_round.sv
`timescale 1ns/100ps

module aes_round (
    input  logic                clk,
    input  logic                res,
    input  logic                load,
    input  aes_pkg::aes_block_u text,
    input  aes_pkg::aes_phase_e phase,
    input  aes_pkg::aes_block_u round_key,
    output aes_pkg::aes_block_u state
);
    import aes_pkg::*;

    aes_block_u add_out;
    aes_block_u sub_out;
    aes_block_u shi_out;
    aes_block_u mix_out;

    // one column times the fixed mix matrix
    function automatic logic [31:0] mix_col(input logic [31:0] c);
        logic [7:0] a0, a1, a2, a3;
        logic [7:0] b0, b1, b2, b3;
        a0 = c[31:24];
        a1 = c[23:16];
        a2 = c[15:8];
        a3 = c[7:0];
        b0 = aes_xtime(a0) ^ aes_xtime(a1) ^ a1 ^ a2 ^ a3;
        b1 = a0 ^ aes_xtime(a1) ^ aes_xtime(a2) ^ a2 ^ a3;
        b2 = a0 ^ a1 ^ aes_xtime(a2) ^ aes_xtime(a3) ^ a3;
        b3 = aes_xtime(a0) ^ a0 ^ a1 ^ a2 ^ aes_xtime(a3);
        return {b0, b1, b2, b3};
    endfunction

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            add_out.bytes[i] = state.bytes[i] ^ round_key.bytes[i];
            sub_out.bytes[i] = aes_sbox(state.bytes[i]);
        end
    end

    // row r rotates left by r columns
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                shi_out.bytes[4*c + r] = state.bytes[4*((c + r) % 4) + r];
            end
        end
    end

    always_comb begin
        for (int c = 0; c < 4; c++) begin
            mix_out.cols[c] = mix_col(state.cols[c]);
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= '0;
        end else if (load) begin
            state <= text;
        end else begin
            case (phase)
                PH_ADD:  state <= add_out;
                PH_SUB:  state <= sub_out;
                PH_SHI:  state <= shi_out;
                PH_MIX:  state <= mix_out;
                default: state <= state;   // exp, idle and done hold
            endcase
        end
    end

endmodule

// File: source/aes_key_sched.sv
`timescale 1ns/100ps

module aes_key_sched (
    input  logic                        clk,
    input  logic                        res,
    input  logic                        load,
    input  aes_pkg::aes_block_u         key,
    input  aes_pkg::aes_phase_e         phase,
    input  logic [aes_pkg::ROUND_W-1:0] round,
    output aes_pkg::aes_block_u         round_key
);
    import aes_pkg::*;

    logic [31:0] rot_w;
    logic [31:0] sub_w;
    logic [31:0] temp_w;
    logic [31:0] w0, w1, w2, w3;

    always_comb begin
        rot_w = {round_key.cols[3][23:0], round_key.cols[3][31:24]};   // rotword
        for (int i = 0; i < 4; i++) begin
            sub_w[8*i +: 8] = aes_sbox(rot_w[8*i +: 8]);
        end
        temp_w = sub_w ^ {aes_rcon(round), 24'h000000};
        w0     = round_key.cols[0] ^ temp_w;
        w1     = round_key.cols[1] ^ w0;
        w2     = round_key.cols[2] ^ w1;
        w3     = round_key.cols[3] ^ w2;
    end

    // round is already advanced here, so this yields key r
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            round_key <= '0;
        end else if (load) begin
            round_key <= key;
        end else if (phase == PH_EXP) begin
            round_key.cols <= {w0, w1, w2, w3};
        end
    end

endmodule

// File: source/aes_core.sv
`timescale 1ns/100ps

module aes_core (
    input  logic                clk,
    input  logic                res,
    input  aes_pkg::aes_req_t   in_req,
    input  logic                in_valid,
    output logic                in_ready,
    output aes_pkg::aes_block_u out_data,
    output logic                out_valid,
    input  logic                out_ready
);
    import aes_pkg::*;

    logic               load;
    aes_phase_e         phase;
    logic [ROUND_W-1:0] round;
    aes_block_u         round_key;

    aes_ctrl ctrl_i (
        .clk       (clk),
        .res       (res),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .load      (load),
        .phase     (phase),
        .round     (round)
    );

    aes_round round_i (
        .clk       (clk),
        .res       (res),
        .load      (load),
        .text      (in_req.text),
        .phase     (phase),
        .round_key (round_key),
        .state     (out_data)   // state doubles as ciphertext
    );

    aes_key_sched key_i (
        .clk       (clk),
        .res       (res),
        .load      (load),
        .key       (in_req.key),
        .phase     (phase),
        .round     (round),
        .round_key (round_key)
    );

endmodule

// File: test/aes_core_chk.sv
`timescale 1ns/100ps

module aes_core_chk (
    input logic                clk,
    input logic                res,
    input logic                in_ready,
    input logic                out_valid,
    input logic                out_ready,
    input aes_pkg::aes_block_u out_data
);

    a_excl: assert property (@(posedge clk) disable iff (!res) !(in_ready && out_valid))
        else $error("in_ready and out_valid high in the same cycle");

    a_hold: assert property (@(posedge clk) disable iff (!res)
        out_valid && !out_ready |=> out_valid)
        else $error("out_valid dropped before out_ready");

    a_stable: assert property (@(posedge clk) disable iff (!res)
        out_valid && !out_ready |=> $stable(out_data))
        else $error("out_data changed while waiting for out_ready");

    // first edge after release
    a_after_reset: assert property (@(posedge clk) $rose(res) |-> in_ready && !out_valid)
        else $error("handshake flags wrong after reset release");

endmodule

bind aes_core aes_core_chk chk_i (
    .clk       (clk),
    .res       (res),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
);

// File: test/aes_core_tb.sv
`timescale 1ns/100ps

module aes_core_tb;
    import aes_pkg::*;

    localparam int CLK_PERIOD       = 8;
    localparam int NUM_BLOCKS       = 1 + 20 + 1 + 5 + 8;
    localparam int CYCLES_PER_BLOCK = 80;
    localparam logic [127:0] KAT_KEY = 128'h000102030405060708090a0b0c0d0e0f;
    localparam logic [127:0] KAT_PT  = 128'h00112233445566778899aabbccddeeff;
    localparam logic [127:0] KAT_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    logic       clk;
    logic       res;
    aes_req_t   in_req;
    logic       in_valid;
    logic       in_ready;
    aes_block_u out_data;
    logic       out_valid;
    logic       out_ready;

    logic [127:0] exp_q[$];
    string        name_q[$];
    int           seed      = 79597;
    int           errors    = 0;
    int           n_tests   = 0;
    int           n_sent    = 0;
    int           n_checked = 0;

    aes_core dut_i (
        .clk       (clk),
        .res       (res),
        .in_req    (in_req),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // FIPS-197 cipher with byte i in row i%4 of column i/4
    function automatic logic [127:0] aes_ref(input logic [127:0] key, input logic [127:0] pt);
        logic [7:0]   s [16];
        logic [7:0]   t [16];
        logic [7:0]   w [16];
        logic [7:0]   g [4];
        logic [127:0] ct;
        for (int i = 0; i < 16; i++) begin
            w[i] = key[127-8*i -: 8];
            s[i] = pt[127-8*i -: 8] ^ w[i];
        end
        for (int rnd = 1; rnd <= 10; rnd++) begin
            g[0] = aes_sbox(w[13]) ^ aes_rcon(4'(rnd));
            g[1] = aes_sbox(w[14]);
            g[2] = aes_sbox(w[15]);
            g[3] = aes_sbox(w[12]);
            for (int i = 0; i < 4; i++) begin
                w[i] = w[i] ^ g[i];
            end
            for (int i = 4; i < 16; i++) begin
                w[i] = w[i] ^ w[i-4];   // chain over new words
            end
            for (int c = 0; c < 4; c++) begin
                for (int r = 0; r < 4; r++) begin
                    t[4*c+r] = aes_sbox(s[4*((c+r)%4)+r]);
                end
            end
            for (int c = 0; c < 4; c++) begin
                for (int r = 0; r < 4; r++) begin
                    if (rnd == 10) begin
                        s[4*c+r] = t[4*c+r];
                    end else begin
                        s[4*c+r] = aes_xtime(t[4*c+r])
                                 ^ aes_xtime(t[4*c+(r+1)%4]) ^ t[4*c+(r+1)%4]
                                 ^ t[4*c+(r+2)%4] ^ t[4*c+(r+3)%4];
                    end
                    s[4*c+r] = s[4*c+r] ^ w[4*c+r];
                end
            end
        end
        for (int i = 0; i < 16; i++) begin
            ct[127-8*i -: 8] = s[i];
        end
        return ct;
    endfunction

    function automatic logic [127:0] rand128();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %0h actual %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic print_result(input string name, input int err_mark);
        n_tests++;
        if (errors == err_mark) begin
            $display("%s ok", name);
        end else begin
            $display("%s failed with %0d errors", name, errors - err_mark);
        end
    endtask

    // called on a rising edge and returns on the transfer edge
    task automatic send(input string name, input logic [127:0] key, input logic [127:0] pt);
        exp_q.push_back(aes_ref(key, pt));
        name_q.push_back(name);
        in_req   <= aes_req_t'({pt, key});
        in_valid <= 1'b1;
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        n_sent++;
    endtask

    task automatic drain();
        @(posedge clk);
        while (exp_q.size() != 0) @(posedge clk);
    endtask

    // transfer happens on the rising edge after this sample
    initial begin
        forever begin
            @(negedge clk);
            if (out_valid && out_ready) begin
                n_checked++;
                if (exp_q.size() == 0) begin
                    $display("output block appeared with no block pending");
                    errors++;
                end else begin
                    check(name_q.pop_front(), exp_q.pop_front(), out_data);
                end
            end
        end
    end

    initial begin
        #(CLK_PERIOD * (NUM_BLOCKS * CYCLES_PER_BLOCK + 100));
        $display("timeout, the DUT stopped answering");
        $display("Checks failed");
        $finish;
    end

    initial begin
        int          err_mark;
        int          lat;
        int          mark;
        int unsigned gap;
        logic        ready_seen;
        res       = 1'b0;
        in_valid  = 1'b0;
        in_req    = '0;
        out_ready = 1'b1;
        repeat (2) @(posedge clk);
        res <= 1'b1;

        err_mark = errors;
        @(negedge clk);
        check("reset", 128'(1), 128'(in_ready));
        check("reset", 128'(0), 128'(out_valid));
        print_result("reset", err_mark);
        @(posedge clk);

        err_mark = errors;
        check("known_ref", KAT_CT, aes_ref(KAT_KEY, KAT_PT));
        send("known_answer", KAT_KEY, KAT_PT);
        in_valid <= 1'b0;
        drain();
        print_result("known_answer", err_mark);

        err_mark = errors;
        repeat (20) begin
            send("random", rand128(), rand128());
            in_valid <= 1'b0;
            drain();
        end
        print_result("random", err_mark);

        err_mark   = errors;
        ready_seen = 1'b0;
        send("latency", rand128(), rand128());
        in_valid <= 1'b0;
        lat = 0;
        @(negedge clk);
        while (!out_valid && lat < 100) begin
            ready_seen = ready_seen | in_ready;
            @(negedge clk);
            lat++;
        end
        check("latency", 128'(50), 128'(lat));
        check("latency_ready", 128'(0), 128'(ready_seen));
        drain();
        print_result("latency", err_mark);

        err_mark = errors;
        repeat (5) begin
            out_ready <= 1'b0;
            send("back_pressure", rand128(), rand128());
            in_valid <= 1'b0;
            @(negedge clk);
            while (!out_valid) @(negedge clk);
            gap = $unsigned($random(seed)) % 16;   // stall of 1 to 16 cycles
            @(posedge clk);
            repeat (gap) @(posedge clk);
            out_ready <= 1'b1;
            drain();
        end
        print_result("back_pressure", err_mark);

        err_mark = errors;
        mark     = n_checked;
        for (int i = 0; i < 8; i++) begin
            send("back_to_back", rand128(), rand128());   // valid stays high
        end
        in_valid <= 1'b0;
        drain();
        repeat (4) @(posedge clk);
        check("back_to_back", 128'(8), 128'(n_checked - mark));
        print_result("back_to_back", err_mark);

        repeat (4) @(posedge clk);
        check("block_count", 128'(n_sent), 128'(n_checked));
        $display("%0d tests, %0d blocks sent, %0d checked, %0d errors",
                 n_tests, n_sent, n_checked, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: aes_core.f
source/aes_pkg.sv
source/aes_ctrl.sv
source/aes_round.sv
source/aes_key_sched.sv
source/aes_core.sv
test/aes_core_chk.sv
test/aes_core_tb.sv

// File: Makefile
SIM   = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = aes_core_tb
FLIST = aes_core.f
LOG   = sim.log
PASS  = All checks passed

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
